// File: project.f
+incdir+tb
rtl/aud_pkg.sv
rtl/play_mode_decode.sv
rtl/aud_dsp.sv
rtl/aud_player.sv
rtl/aud_playback_top.sv
tb/tb_aud_playback.sv

// File: Makefile
TOP := tb_aud_playback

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/aud_model.svh
`ifndef AUD_MODEL_SVH
`define AUD_MODEL_SVH

// expected word list for one playback, built from mem[] and left in exp_q
task automatic build_expected(input play_mode_e mode, input int speed, input int len);
	int a;
	int b;
	int st;
	int i;
	int j;
	int k;
	exp_q.delete();
	case (mode)
		MODE_FAST: begin
			// only whole strides of speed samples
			for (k = 0; k < len / speed; k++)
				exp_q.push_back(mem[k * speed]);
		end
		MODE_HOLD: begin
			for (j = 0; j < len - 1; j++)
				for (i = 0; i < speed; i++)
					exp_q.push_back(mem[j]);
			exp_q.push_back(mem[len - 1]);
		end
		default: begin
			for (j = 0; j < len - 1; j++) begin
				a = $signed(mem[j]);
				b = $signed(mem[j + 1]);
				// integer division truncates toward zero
				st = (b - a) / speed;
				for (i = 0; i < speed; i++)
					exp_q.push_back(16'(a + i * st));
			end
			// last sample has no successor
			exp_q.push_back(mem[len - 1]);
		end
	endcase
endtask

`endif

// File: tb/tb_aud_playback.sv
`timescale 1ns/10ps
`default_nettype none

module tb_aud_playback import aud_pkg::*; ();

	localparam int NUM_RUNS = 15;
	localparam int STOP_WORDS = 4;

	logic clk;
	logic rst_n;
	logic start;
	logic stop;
	logic pause;
	logic [3:0] speed;
	logic fast, slow_0, slow_1;
	logic daclrck;
	logic [REC_ADDR_W-1:0] record_len;
	logic [SAMPLE_W-1:0] sram_data;
	logic [REC_ADDR_W-1:0] sram_addr;
	logic aud_dacdat, aud_frame, finish;

	logic [SAMPLE_W-1:0] mem [0:1023];
	logic [SAMPLE_W-1:0] exp_q [$];
	logic [SAMPLE_W-1:0] got_q [$];
	logic [SAMPLE_W-1:0] word_acc = '0;
	logic pause_d1 = 1'b0;
	logic pause_d2 = 1'b0;
	int seed;
	int frame_count = 0;
	int finish_count = 0;
	int bits_left = 0;
	int budget_cycles;
	bit pause_on = 1'b0;
	bit budget_ready = 1'b0;

	play_mode_e run_mode [NUM_RUNS];
	logic [3:0] run_speed_in [NUM_RUNS];
	int run_speed [NUM_RUNS];
	int run_len [NUM_RUNS];
	bit run_pause [NUM_RUNS];

	`include "aud_model.svh"

	aud_playback_top #(.MAX_SPEED(8)) dut0 (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_start(start),
		.i_stop(stop),
		.i_pause(pause),
		.i_speed(speed),
		.i_fast(fast),
		.i_slow_0(slow_0),
		.i_slow_1(slow_1),
		.i_daclrck(daclrck),
		.i_record_len(record_len),
		.i_sram_data(sram_data),
		.o_sram_addr(sram_addr),
		.o_aud_dacdat(aud_dacdat),
		.o_aud_frame(aud_frame),
		.o_finish(finish)
	);

	// asynchronous sram, data follows the address
	assign sram_data = mem[sram_addr[9:0]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		daclrck = 1'b0;
		forever begin
			repeat (20) @(posedge clk);
			#1 daclrck = ~daclrck;
		end
	end

	// pauses of 1..12 cycles with gaps of 21..84 cycles
	initial begin : pause_gen
		int hold;
		hold = 0;
		pause = 1'b0;
		forever begin
			@(posedge clk);
			if (!pause_on) begin
				hold = 0;
				#1 pause = 1'b0;
			end else if (hold > 0) begin
				hold--;
			end else if (pause) begin
				hold = 20 + {$random(seed)} % 64;
				#1 pause = 1'b0;
			end else begin
				hold = {$random(seed)} % 12;
				#1 pause = 1'b1;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// word capture, 16 bits after each frame cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (finish)
				finish_count++;
			if (aud_frame) begin
				frame_count++;
				// pause as seen when the enable rose
				check_value("pause at frame start", pause_d2, 0);
				bits_left = 16;
			end else if (bits_left > 0) begin
				word_acc = {word_acc[SAMPLE_W-2:0], aud_dacdat};
				bits_left--;
				if (bits_left == 0)
					got_q.push_back(word_acc);
			end
		end
		pause_d2 = pause_d1;
		pause_d1 = pause;
	end

	initial begin : watchdog
		wait (budget_ready);
		repeat (budget_cycles) @(posedge clk);
		$display("playback did not finish in time");
		$display("tests failed");
		$fatal(1, "timeout");
	end

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// extra mode levels are set at random to exercise the priority
	task automatic start_play(input play_mode_e mode, input logic [3:0] speed_in,
			input int len);
		int noise;
		noise = $random(seed);
		fast = (mode == MODE_FAST);
		slow_0 = (mode == MODE_HOLD) || (mode == MODE_FAST && noise[0]);
		slow_1 = (mode == MODE_LINEAR) || noise[1];
		speed = speed_in;
		record_len = REC_ADDR_W'(len);
		start = 1'b1;
		wait_cycles(1);
		start = 1'b0;
	endtask

	task automatic play_and_check(input play_mode_e mode, input logic [3:0] speed_in,
			input int speed_eff, input int len, input bit with_pause);
		int base;
		int fin_base;
		int n;
		build_expected(mode, speed_eff, len);
		base = got_q.size();
		fin_base = finish_count;
		start_play(mode, speed_in, len);
		pause_on = with_pause;
		while (finish_count == fin_base)
			wait_cycles(1);
		pause_on = 1'b0;
		wait_cycles(20);
		check_value("o_finish pulses", finish_count - fin_base, 1);
		check_value("word count", got_q.size() - base, exp_q.size());
		for (n = 0; n < exp_q.size(); n++)
			check_value($sformatf("o_aud_dacdat word %0d", n), got_q[base + n], exp_q[n]);
	endtask

	task automatic stop_and_replay();
		int base;
		int fin_base;
		int frames;
		base = got_q.size();
		fin_base = finish_count;
		start_play(MODE_HOLD, 4'd3, 40);
		while (got_q.size() - base < STOP_WORDS)
			wait_cycles(1);
		// somewhere inside the next word
		wait_cycles(30);
		stop = 1'b1;
		wait_cycles(1);
		stop = 1'b0;
		while (finish_count == fin_base)
			wait_cycles(1);
		frames = frame_count;
		wait_cycles(40);
		check_value("o_finish pulses after stop", finish_count - fin_base, 1);
		check_value("o_aud_frame after o_finish", frame_count, frames);
		check_value("o_sram_addr after stop", sram_addr, 0);
		play_and_check(MODE_HOLD, 4'd3, 3, 40, 1'b0);
	endtask

	initial begin : main_seq
		int total;
		int n;
		int frames;
		int fin_base;
		seed = 33;
		rst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		speed = 4'd1;
		fast = 1'b0;
		slow_0 = 1'b0;
		slow_1 = 1'b0;
		record_len = '0;
		for (n = 0; n < 1024; n++)
			mem[n] = $random(seed);
		// every mode in turn, pauses in the second half
		for (n = 0; n < NUM_RUNS - 3; n++) begin
			run_mode[n] = play_mode_e'(n % 3);
			run_speed[n] = 1 + {$random(seed)} % 8;
			run_speed_in[n] = 4'(run_speed[n]);
			run_len[n] = 8 + {$random(seed)} % 57;
			run_pause[n] = (n >= (NUM_RUNS - 3) / 2);
		end
		// out of range speeds clamp to 1 and 8
		run_mode[12] = MODE_FAST;
		run_speed_in[12] = 4'd0;
		run_speed[12] = 1;
		run_len[12] = 24;
		run_pause[12] = 1'b0;
		run_mode[13] = MODE_HOLD;
		run_speed_in[13] = 4'd12;
		run_speed[13] = 8;
		run_len[13] = 12;
		run_pause[13] = 1'b1;
		run_mode[14] = MODE_LINEAR;
		run_speed_in[14] = 4'd15;
		run_speed[14] = 8;
		run_len[14] = 10;
		run_pause[14] = 1'b0;
		total = STOP_WORDS + 2;
		build_expected(MODE_HOLD, 3, 40);
		total += exp_q.size();
		for (n = 0; n < NUM_RUNS; n++) begin
			build_expected(run_mode[n], run_speed[n], run_len[n]);
			total += exp_q.size();
		end
		budget_cycles = 40 * total + 2000;
		budget_ready = 1'b1;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		wait_cycles(5);
		for (n = 0; n < NUM_RUNS; n++)
			play_and_check(run_mode[n], run_speed_in[n], run_speed[n], run_len[n],
				run_pause[n]);
		stop_and_replay();
		// start with no mode level must be ignored
		frames = frame_count;
		fin_base = finish_count;
		fast = 1'b0;
		slow_0 = 1'b0;
		slow_1 = 1'b0;
		start = 1'b1;
		wait_cycles(1);
		start = 1'b0;
		wait_cycles(100);
		check_value("o_aud_frame without mode", frame_count, frames);
		check_value("o_finish without mode", finish_count, fin_base);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/aud_playback_top.sv
`timescale 1ns/10ps
`default_nettype none

module aud_playback_top import aud_pkg::*; #(
	parameter int MAX_SPEED = 8
) (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire logic i_start,
	input  wire logic i_stop,
	input  wire logic i_pause,
	input  wire logic [3:0] i_speed,
	input  wire logic i_fast,
	input  wire logic i_slow_0,
	input  wire logic i_slow_1,
	input  wire logic i_daclrck,
	input  wire logic [REC_ADDR_W-1:0] i_record_len,
	input  wire logic [SAMPLE_W-1:0] i_sram_data,
	output logic [REC_ADDR_W-1:0] o_sram_addr,
	output logic o_aud_dacdat,
	output logic o_aud_frame,
	output logic o_finish
);

	play_cmd_t cmd;
	logic player_en;
	logic sent_finish;
	logic [SAMPLE_W-1:0] sample;

	play_mode_decode #(.MAX_SPEED(MAX_SPEED)) decode0 (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_pause(i_pause),
		.i_speed(i_speed),
		.i_fast(i_fast),
		.i_slow_0(i_slow_0),
		.i_slow_1(i_slow_1),
		.i_record_len(i_record_len),
		.o_cmd(cmd)
	);

	aud_dsp #(.MAX_SPEED(MAX_SPEED)) dsp0 (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_cmd(cmd),
		.i_stop(i_stop),
		.i_pause(i_pause),
		.i_daclrck(i_daclrck),
		.i_sent_finish(sent_finish),
		.i_sram_data(i_sram_data),
		.o_sram_addr(o_sram_addr),
		.o_sample(sample),
		.o_player_en(player_en),
		.o_finish(o_finish)
	);

	// serializer is the result stage
	aud_player player0 (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_en(player_en),
		.i_sample(sample),
		.o_dacdat(o_aud_dacdat),
		.o_frame(o_aud_frame),
		.o_sent_finish(sent_finish)
	);

endmodule

`default_nettype wire

// File: rtl/aud_player.sv
`timescale 1ns/10ps
`default_nettype none

module aud_player import aud_pkg::*; (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire logic i_en,
	input  wire logic [SAMPLE_W-1:0] i_sample,
	output logic o_dacdat,
	output logic o_frame,
	output logic o_sent_finish
);

	localparam int BIT_W = $clog2(SAMPLE_W);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FRAME,
		S_DATA,
		S_DONE
	} state_e;

	state_e state_r;
	logic [BIT_W-1:0] bit_cnt_r;
	logic [SAMPLE_W-1:0] shift_r;
	logic dacdat_r;
	logic frame_r;
	logic sent_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= S_IDLE;
			bit_cnt_r <= '0;
			dacdat_r <= 1'b0;
			frame_r <= 1'b0;
			sent_r <= 1'b0;
		end else begin
			frame_r <= 1'b0;
			sent_r <= 1'b0;
			case (state_r)
				S_IDLE: begin
					if (i_en) begin
						frame_r <= 1'b1;
						state_r <= S_FRAME;
					end
				end
				S_FRAME: begin
					if (!i_en) begin
						state_r <= S_IDLE;
					end else begin
						dacdat_r <= i_sample[SAMPLE_W-1];
						bit_cnt_r <= '0;
						state_r <= S_DATA;
					end
				end
				S_DATA: begin
					// enable dropped mid word, abandon it
					if (!i_en) begin
						dacdat_r <= 1'b0;
						state_r <= S_IDLE;
					end else if (bit_cnt_r == BIT_W'(SAMPLE_W - 1)) begin
						dacdat_r <= 1'b0;
						sent_r <= 1'b1;
						state_r <= S_DONE;
					end else begin
						dacdat_r <= shift_r[SAMPLE_W-1];
						bit_cnt_r <= bit_cnt_r + 1'b1;
					end
				end
				// one word per enable
				S_DONE: if (!i_en) state_r <= S_IDLE;
				default: state_r <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == S_FRAME)
			shift_r <= {i_sample[SAMPLE_W-2:0], 1'b0};
		else if (state_r == S_DATA)
			shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
	end

	assign o_dacdat = dacdat_r;
	assign o_frame = frame_r;
	assign o_sent_finish = sent_r;

	a_sent_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_sent_finish |=> !o_sent_finish);

endmodule

`default_nettype wire

// File: rtl/aud_dsp.sv
`timescale 1ns/10ps
`default_nettype none

module aud_dsp import aud_pkg::*; #(
	parameter int MAX_SPEED = 8
) (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire play_cmd_t i_cmd,
	input  wire logic i_stop,
	input  wire logic i_pause,
	input  wire logic i_daclrck,
	input  wire logic i_sent_finish,
	input  wire logic [SAMPLE_W-1:0] i_sram_data,
	output logic [REC_ADDR_W-1:0] o_sram_addr,
	output logic [SAMPLE_W-1:0] o_sample,
	output logic o_player_en,
	output logic o_finish
);

	localparam int PH_W = $clog2(MAX_SPEED + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FAST_FETCH,
		S_FAST_SEND,
		S_SLOW_FETCH,
		S_SLOW_SEND
	} state_e;

	state_e state_r;
	logic [REC_ADDR_W-1:0] addr_r;
	logic [CNT_W-1:0] sent_cnt_r;
	logic [PH_W-1:0] phase_r;
	logic [1:0] fetch_cnt_r;
	logic player_en_r;
	logic finish_r;
	logic stop_d_r;

	logic signed [SAMPLE_W-1:0] sram1_r;
	logic signed [SAMPLE_W-1:0] sram2_r;
	logic signed [SAMPLE_W-1:0] sample_r;

	logic signed [SAMPLE_W:0] diff;
	logic signed [SAMPLE_W:0] step_full;
	logic signed [SAMPLE_W-1:0] step;
	logic [PH_W-1:0] phase_inc;
	logic phase_wrap;
	logic stop_rise;
	logic [CNT_W-1:0] words_sel;
	logic last_word;

	// 17 bit difference so large swings do not overflow
	assign diff = sram2_r - sram1_r;
	assign step_full = diff / $signed({1'b0, i_cmd.speed});
	assign step = step_full[SAMPLE_W-1:0];

	assign phase_inc = phase_r + 1'b1;
	assign phase_wrap = (phase_inc == PH_W'(i_cmd.speed));
	assign stop_rise = i_stop && !stop_d_r;

	assign words_sel = (state_r == S_FAST_SEND) ? i_cmd.fast_words : i_cmd.slow_words;
	assign last_word = (sent_cnt_r >= words_sel);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= S_IDLE;
			addr_r <= '0;
			sent_cnt_r <= '0;
			phase_r <= '0;
			fetch_cnt_r <= '0;
			player_en_r <= 1'b0;
			finish_r <= 1'b0;
			stop_d_r <= 1'b0;
		end else begin
			stop_d_r <= i_stop;
			finish_r <= stop_rise;
			if (i_stop) begin
				state_r <= S_IDLE;
				addr_r <= '0;
				sent_cnt_r <= '0;
				phase_r <= '0;
				fetch_cnt_r <= '0;
				player_en_r <= 1'b0;
			end else begin
				case (state_r)
					S_IDLE: begin
						addr_r <= '0;
						sent_cnt_r <= '0;
						phase_r <= '0;
						fetch_cnt_r <= '0;
						if (i_cmd.go)
							state_r <= (i_cmd.mode == MODE_FAST) ? S_FAST_FETCH : S_SLOW_FETCH;
					end
					S_FAST_FETCH: begin
						// skip ahead by speed
						addr_r <= addr_r + REC_ADDR_W'(i_cmd.speed);
						sent_cnt_r <= sent_cnt_r + 1'b1;
						state_r <= S_FAST_SEND;
					end
					S_SLOW_FETCH: begin
						fetch_cnt_r <= fetch_cnt_r + 1'b1;
						case (fetch_cnt_r)
							2'd0: addr_r <= addr_r + 1'b1;
							// back to j unless this was the last phase of j
							2'd1: if (!phase_wrap) addr_r <= addr_r - 1'b1;
							default: begin
								fetch_cnt_r <= '0;
								phase_r <= phase_wrap ? '0 : phase_inc;
								sent_cnt_r <= sent_cnt_r + 1'b1;
								state_r <= S_SLOW_SEND;
							end
						endcase
					end
					S_FAST_SEND, S_SLOW_SEND: begin
						if (player_en_r && i_sent_finish) begin
							player_en_r <= 1'b0;
							if (last_word) begin
								state_r <= S_IDLE;
								addr_r <= '0;
								finish_r <= 1'b1;
							end else if (state_r == S_FAST_SEND) begin
								state_r <= S_FAST_FETCH;
							end else begin
								state_r <= S_SLOW_FETCH;
							end
						end else if (!player_en_r && i_daclrck && !i_pause) begin
							player_en_r <= 1'b1;
						end
					end
					default: state_r <= S_IDLE;
				endcase
			end
		end
	end

	// sample path
	always_ff @(posedge i_clk) begin
		if (state_r == S_FAST_FETCH)
			sample_r <= i_sram_data;
		if (state_r == S_SLOW_FETCH) begin
			if (fetch_cnt_r == 2'd0)
				sram1_r <= i_sram_data;
			if (fetch_cnt_r == 2'd1)
				sram2_r <= i_sram_data;
			if (fetch_cnt_r == 2'd2) begin
				if (i_cmd.mode == MODE_LINEAR && phase_r != '0)
					sample_r <= sample_r + step;
				else
					sample_r <= sram1_r;
			end
		end
	end

	assign o_sram_addr = addr_r;
	assign o_sample = sample_r;
	assign o_player_en = player_en_r;
	assign o_finish = finish_r;

	a_en_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_player_en) |-> $past(i_daclrck && !i_pause));

	a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |=> !o_finish);

	a_phase_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		phase_r < PH_W'(MAX_SPEED));

endmodule

`default_nettype wire

// File: rtl/play_mode_decode.sv
`timescale 1ns/10ps
`default_nettype none

module play_mode_decode import aud_pkg::*; #(
	parameter int MAX_SPEED = 8
) (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire logic i_start,
	input  wire logic i_pause,
	input  wire logic [3:0] i_speed,
	input  wire logic i_fast,
	input  wire logic i_slow_0,
	input  wire logic i_slow_1,
	input  wire logic [REC_ADDR_W-1:0] i_record_len,
	output play_cmd_t o_cmd
);

	logic [3:0] speed_c;
	play_mode_e mode_c;
	logic start_ok;

	logic go_r;
	play_mode_e mode_r;
	logic [3:0] speed_r;
	logic [CNT_W-1:0] fast_words_r;
	logic [CNT_W-1:0] slow_words_r;

	// clamp speed into 1..MAX_SPEED
	always_comb begin
		if (i_speed == 4'd0)
			speed_c = 4'd1;
		else if (i_speed > 4'(MAX_SPEED))
			speed_c = 4'(MAX_SPEED);
		else
			speed_c = i_speed;
	end

	// fast wins over hold, hold over linear
	always_comb begin
		if (i_fast)
			mode_c = MODE_FAST;
		else if (i_slow_0)
			mode_c = MODE_HOLD;
		else
			mode_c = MODE_LINEAR;
	end

	assign start_ok = i_start && !i_pause && (i_fast || i_slow_0 || i_slow_1);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			go_r <= 1'b0;
			mode_r <= MODE_FAST;
			speed_r <= 4'd1;
		end else begin
			go_r <= start_ok;
			if (start_ok) begin
				mode_r <= mode_c;
				speed_r <= speed_c;
			end
		end
	end

	// word counts computed once per start
	always_ff @(posedge i_clk) begin
		if (start_ok) begin
			fast_words_r <= CNT_W'(i_record_len) / CNT_W'(speed_c);
			slow_words_r <= CNT_W'(speed_c) * (CNT_W'(i_record_len) - CNT_W'(1)) + CNT_W'(1);
		end
	end

	assign o_cmd = '{
		mode: mode_r,
		speed: speed_r,
		fast_words: fast_words_r,
		slow_words: slow_words_r,
		go: go_r
	};

	a_speed_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd.speed >= 4'd1 && o_cmd.speed <= 4'(MAX_SPEED));

endmodule

`default_nettype wire

// File: rtl/aud_pkg.sv
`default_nettype none

package aud_pkg;

	// external sram geometry
	localparam int REC_ADDR_W = 20;
	localparam int SAMPLE_W = 16;

	// enough for MAX_SPEED times the full address range
	localparam int CNT_W = 24;

	typedef enum logic [1:0] {
		MODE_FAST = 2'd0,
		MODE_HOLD = 2'd1,
		MODE_LINEAR = 2'd2
	} play_mode_e;

	// registered playback command, decode to execute
	typedef struct packed {
		play_mode_e mode;
		logic [3:0] speed;
		// record length / speed, truncated
		logic [CNT_W-1:0] fast_words;
		// speed * (length - 1) + 1
		logic [CNT_W-1:0] slow_words;
		// one cycle start strobe
		logic go;
	} play_cmd_t;

endpackage

`default_nettype wire
